//--- design/udp_echo_pkg.sv
/*
 * Echo application package: port and FIFO constants, header field types
 * and FSM state encodings for the filter and transmit sequencer
 */
`default_nettype none

package udp_echo_pkg;

    // Header and payload field types
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    // Only frames to this port come back
    localparam udp_port_t ECHO_PORT = 16'd1234;

    // Payload buffer, depth must be a power of two
    localparam int PAYLOAD_FIFO_DEPTH  = 256;
    localparam int PAYLOAD_FIFO_ADDR_W = 8;

    // Receive filter states
    typedef enum logic [1:0] {
        FILTER_IDLE,
        FILTER_FORWARD,
        FILTER_DROP
    } filter_state_t;

    // Transmit sequencer states
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_HEADER,
        TX_PAYLOAD
    } echo_tx_state_t;

endpackage

`default_nettype wire

//--- design/udp_rx_filter.sv
/*
 * Receive filter: matches the UDP destination port against the echo port,
 * hands a swapped reply request to the sequencer, forwards or drops payload
 */
`timescale 1ns/1ps
`default_nettype none

module udp_rx_filter (
    input  wire                             clk_125mhz,
    input  wire                             rst_125mhz,

    // Received UDP header
    input  wire                             rx_udp_hdr_valid,
    output logic                            rx_udp_hdr_ready,
    input  wire udp_echo_pkg::ip_addr_t     rx_udp_ip_source_ip,
    input  wire udp_echo_pkg::udp_port_t    rx_udp_source_port,
    input  wire udp_echo_pkg::udp_port_t    rx_udp_dest_port,
    input  wire udp_echo_pkg::udp_len_t     rx_udp_length,

    // Received UDP payload
    input  wire udp_echo_pkg::byte_t        rx_udp_payload_tdata,
    input  wire                             rx_udp_payload_tvalid,
    output logic                            rx_udp_payload_tready,
    input  wire                             rx_udp_payload_tlast,
    input  wire                             rx_udp_payload_tuser,

    // Reply request to the transmit sequencer
    output logic                            echo_hdr_valid,
    input  wire                             echo_hdr_ready,
    output udp_echo_pkg::ip_addr_t          echo_dest_ip,
    output udp_echo_pkg::udp_port_t         echo_source_port,
    output udp_echo_pkg::udp_port_t         echo_dest_port,
    output udp_echo_pkg::udp_len_t          echo_length,

    // Payload into the FIFO
    output udp_echo_pkg::byte_t             fifo_in_tdata,
    output logic                            fifo_in_tvalid,
    input  wire                             fifo_in_tready,
    output logic                            fifo_in_tlast,
    output logic                            fifo_in_tuser
);

    udp_echo_pkg::filter_state_t state;
    udp_echo_pkg::filter_state_t state_next;
    logic port_match;
    logic hdr_fire;
    logic last_fire;

    assign port_match = (rx_udp_dest_port == udp_echo_pkg::ECHO_PORT);

    // A dropped header goes at once, a kept one waits for the sequencer
    assign rx_udp_hdr_ready = (state == udp_echo_pkg::FILTER_IDLE) &&
                              (!port_match || echo_hdr_ready);
    assign hdr_fire = rx_udp_hdr_valid && rx_udp_hdr_ready;

    // Reply fields, source and destination swapped
    assign echo_hdr_valid   = (state == udp_echo_pkg::FILTER_IDLE) &&
                              rx_udp_hdr_valid && port_match;
    assign echo_dest_ip     = rx_udp_ip_source_ip;
    assign echo_source_port = rx_udp_dest_port;
    assign echo_dest_port   = rx_udp_source_port;
    assign echo_length      = rx_udp_length;

    // Payload path, FIFO back-pressure stalls the stack
    assign fifo_in_tdata  = rx_udp_payload_tdata;
    assign fifo_in_tlast  = rx_udp_payload_tlast;
    assign fifo_in_tuser  = rx_udp_payload_tuser;
    assign fifo_in_tvalid = (state == udp_echo_pkg::FILTER_FORWARD) && rx_udp_payload_tvalid;

    // Dropped payload is swallowed without a stall
    assign rx_udp_payload_tready = (state == udp_echo_pkg::FILTER_DROP) ||
                                   ((state == udp_echo_pkg::FILTER_FORWARD) && fifo_in_tready);

    assign last_fire = rx_udp_payload_tvalid && rx_udp_payload_tready && rx_udp_payload_tlast;

    always_comb begin
        state_next = state;
        case (state)
            udp_echo_pkg::FILTER_IDLE: begin
                if (hdr_fire) begin
                    state_next = port_match ? udp_echo_pkg::FILTER_FORWARD
                                            : udp_echo_pkg::FILTER_DROP;
                end
            end
            udp_echo_pkg::FILTER_FORWARD,
            udp_echo_pkg::FILTER_DROP: begin
                if (last_fire) begin
                    state_next = udp_echo_pkg::FILTER_IDLE;
                end
            end
            default: begin
                state_next = udp_echo_pkg::FILTER_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state <= udp_echo_pkg::FILTER_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // A stalled reply request holds until the sequencer takes it
    echo_req_stable_while_stalled: assert property (
        @(posedge clk_125mhz) disable iff (rst_125mhz)
        (echo_hdr_valid && !echo_hdr_ready) |=>
            (echo_hdr_valid && $stable(echo_dest_ip) && $stable(echo_source_port) &&
             $stable(echo_dest_port) && $stable(echo_length))
    );

endmodule

`default_nettype wire

//--- design/udp_payload_fifo.sv
/*
 * Payload FIFO: circular byte buffer carrying tlast and tuser per entry,
 * full and empty from pointers one bit wider than the address
 */
`timescale 1ns/1ps
`default_nettype none

module udp_payload_fifo (
    input  wire                         clk_125mhz,
    input  wire                         rst_125mhz,

    // Write side
    input  wire udp_echo_pkg::byte_t    fifo_in_tdata,
    input  wire                         fifo_in_tvalid,
    output logic                        fifo_in_tready,
    input  wire                         fifo_in_tlast,
    input  wire                         fifo_in_tuser,

    // Read side
    output udp_echo_pkg::byte_t         fifo_out_tdata,
    output logic                        fifo_out_tvalid,
    input  wire                         fifo_out_tready,
    output logic                        fifo_out_tlast,
    output logic                        fifo_out_tuser
);

    udp_echo_pkg::byte_t mem_data [udp_echo_pkg::PAYLOAD_FIFO_DEPTH];
    logic                mem_last [udp_echo_pkg::PAYLOAD_FIFO_DEPTH];
    logic                mem_user [udp_echo_pkg::PAYLOAD_FIFO_DEPTH];

    logic [udp_echo_pkg::PAYLOAD_FIFO_ADDR_W:0]   wr_ptr;
    logic [udp_echo_pkg::PAYLOAD_FIFO_ADDR_W:0]   rd_ptr;
    logic [udp_echo_pkg::PAYLOAD_FIFO_ADDR_W-1:0] wr_addr;
    logic [udp_echo_pkg::PAYLOAD_FIFO_ADDR_W-1:0] rd_addr;
    logic [udp_echo_pkg::PAYLOAD_FIFO_ADDR_W:0]   occupancy;
    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;

    assign wr_addr   = wr_ptr[udp_echo_pkg::PAYLOAD_FIFO_ADDR_W-1:0];
    assign rd_addr   = rd_ptr[udp_echo_pkg::PAYLOAD_FIFO_ADDR_W-1:0];
    assign occupancy = wr_ptr - rd_ptr;

    // Same address with the wrap bit differing means one lap ahead
    assign full  = (wr_addr == rd_addr) &&
                   (wr_ptr[udp_echo_pkg::PAYLOAD_FIFO_ADDR_W] !=
                    rd_ptr[udp_echo_pkg::PAYLOAD_FIFO_ADDR_W]);
    assign empty = (wr_ptr == rd_ptr);

    assign fifo_in_tready  = !full;
    assign fifo_out_tvalid = !empty;
    assign wr_en = fifo_in_tvalid && fifo_in_tready;
    assign rd_en = fifo_out_tvalid && fifo_out_tready;

    // Head entry read straight out, visible the cycle after its write
    assign fifo_out_tdata = mem_data[rd_addr];
    assign fifo_out_tlast = mem_last[rd_addr];
    assign fifo_out_tuser = mem_user[rd_addr];

    always_ff @(posedge clk_125mhz) begin
        if (wr_en) begin
            mem_data[wr_addr] <= fifo_in_tdata;
            mem_last[wr_addr] <= fifo_in_tlast;
            mem_user[wr_addr] <= fifo_in_tuser;
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // A write while full or a read while empty pushes the count past the depth
    no_write_when_full: assert property (
        @(posedge clk_125mhz) disable iff (rst_125mhz)
        occupancy <= udp_echo_pkg::PAYLOAD_FIFO_DEPTH
    );

    // Head entry holds while the sequencer stalls
    head_stable_while_stalled: assert property (
        @(posedge clk_125mhz) disable iff (rst_125mhz)
        (fifo_out_tvalid && !fifo_out_tready) |=>
            (fifo_out_tvalid && $stable(fifo_out_tdata) &&
             $stable(fifo_out_tlast) && $stable(fifo_out_tuser))
    );

endmodule

`default_nettype wire

//--- design/udp_echo_tx.sv
/*
 * Transmit sequencer: registers the reply header, presents it to the stack,
 * streams one frame of payload from the FIFO and latches its first byte on led
 */
`timescale 1ns/1ps
`default_nettype none

module udp_echo_tx (
    input  wire                             clk_125mhz,
    input  wire                             rst_125mhz,

    // Reply request from the filter
    input  wire                             echo_hdr_valid,
    output logic                            echo_hdr_ready,
    input  wire udp_echo_pkg::ip_addr_t     echo_dest_ip,
    input  wire udp_echo_pkg::udp_port_t    echo_source_port,
    input  wire udp_echo_pkg::udp_port_t    echo_dest_port,
    input  wire udp_echo_pkg::udp_len_t     echo_length,

    // Payload from the FIFO
    input  wire udp_echo_pkg::byte_t        fifo_out_tdata,
    input  wire                             fifo_out_tvalid,
    output logic                            fifo_out_tready,
    input  wire                             fifo_out_tlast,
    input  wire                             fifo_out_tuser,

    // Transmit UDP header
    output logic                            tx_udp_hdr_valid,
    input  wire                             tx_udp_hdr_ready,
    output udp_echo_pkg::ip_addr_t          tx_udp_ip_dest_ip,
    output udp_echo_pkg::udp_port_t         tx_udp_source_port,
    output udp_echo_pkg::udp_port_t         tx_udp_dest_port,
    output udp_echo_pkg::udp_len_t          tx_udp_length,

    // Transmit UDP payload
    output udp_echo_pkg::byte_t             tx_udp_payload_tdata,
    output logic                            tx_udp_payload_tvalid,
    input  wire                             tx_udp_payload_tready,
    output logic                            tx_udp_payload_tlast,
    output logic                            tx_udp_payload_tuser,

    output udp_echo_pkg::byte_t             led
);

    udp_echo_pkg::echo_tx_state_t state;
    udp_echo_pkg::echo_tx_state_t state_next;
    logic echo_fire;
    logic hdr_fire;
    logic payload_fire;
    // Set until the first byte of the current frame has gone out
    logic first_byte;

    assign echo_hdr_ready   = (state == udp_echo_pkg::TX_IDLE);
    assign echo_fire        = echo_hdr_valid && echo_hdr_ready;
    assign tx_udp_hdr_valid = (state == udp_echo_pkg::TX_HEADER);
    assign hdr_fire         = tx_udp_hdr_valid && tx_udp_hdr_ready;

    // FIFO output passes through only while sending payload
    assign tx_udp_payload_tdata  = fifo_out_tdata;
    assign tx_udp_payload_tlast  = fifo_out_tlast;
    assign tx_udp_payload_tuser  = fifo_out_tuser;
    assign tx_udp_payload_tvalid = (state == udp_echo_pkg::TX_PAYLOAD) && fifo_out_tvalid;
    assign fifo_out_tready       = (state == udp_echo_pkg::TX_PAYLOAD) && tx_udp_payload_tready;
    assign payload_fire          = tx_udp_payload_tvalid && tx_udp_payload_tready;

    always_comb begin
        state_next = state;
        case (state)
            udp_echo_pkg::TX_IDLE: begin
                if (echo_fire) begin
                    state_next = udp_echo_pkg::TX_HEADER;
                end
            end
            udp_echo_pkg::TX_HEADER: begin
                if (hdr_fire) begin
                    state_next = udp_echo_pkg::TX_PAYLOAD;
                end
            end
            udp_echo_pkg::TX_PAYLOAD: begin
                if (payload_fire && tx_udp_payload_tlast) begin
                    state_next = udp_echo_pkg::TX_IDLE;
                end
            end
            default: begin
                state_next = udp_echo_pkg::TX_IDLE;
            end
        endcase
    end

    // Reply header held until the stack takes it
    always_ff @(posedge clk_125mhz) begin
        if (echo_fire) begin
            tx_udp_ip_dest_ip  <= echo_dest_ip;
            tx_udp_source_port <= echo_source_port;
            tx_udp_dest_port   <= echo_dest_port;
            tx_udp_length      <= echo_length;
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state      <= udp_echo_pkg::TX_IDLE;
            first_byte <= 1'b0;
            led        <= '0;
        end else begin
            state <= state_next;
            if (hdr_fire) begin
                first_byte <= 1'b1;
            end else if (payload_fire) begin
                first_byte <= 1'b0;
            end
            if (payload_fire && first_byte) begin
                led <= tx_udp_payload_tdata;
            end
        end
    end

    // Stalled header must not change under the stack
    hdr_stable_while_stalled: assert property (
        @(posedge clk_125mhz) disable iff (rst_125mhz)
        (tx_udp_hdr_valid && !tx_udp_hdr_ready) |=>
            (tx_udp_hdr_valid && $stable(tx_udp_ip_dest_ip) &&
             $stable(tx_udp_source_port) && $stable(tx_udp_dest_port) &&
             $stable(tx_udp_length))
    );

endmodule

`default_nettype wire

//--- design/udp_echo_core.sv
/*
 * UDP echo core: receive filter, payload FIFO and transmit sequencer
 */
`timescale 1ns/1ps
`default_nettype none

module udp_echo_core (
    input  wire                             clk_125mhz,
    input  wire                             rst_125mhz,

    // Received UDP frames from the stack
    input  wire                             rx_udp_hdr_valid,
    output wire                             rx_udp_hdr_ready,
    input  wire udp_echo_pkg::ip_addr_t     rx_udp_ip_source_ip,
    input  wire udp_echo_pkg::udp_port_t    rx_udp_source_port,
    input  wire udp_echo_pkg::udp_port_t    rx_udp_dest_port,
    input  wire udp_echo_pkg::udp_len_t     rx_udp_length,
    input  wire udp_echo_pkg::byte_t        rx_udp_payload_tdata,
    input  wire                             rx_udp_payload_tvalid,
    output wire                             rx_udp_payload_tready,
    input  wire                             rx_udp_payload_tlast,
    input  wire                             rx_udp_payload_tuser,

    // Echoed UDP frames to the stack
    output wire                             tx_udp_hdr_valid,
    input  wire                             tx_udp_hdr_ready,
    output wire udp_echo_pkg::ip_addr_t     tx_udp_ip_dest_ip,
    output wire udp_echo_pkg::udp_port_t    tx_udp_source_port,
    output wire udp_echo_pkg::udp_port_t    tx_udp_dest_port,
    output wire udp_echo_pkg::udp_len_t     tx_udp_length,
    output wire udp_echo_pkg::byte_t        tx_udp_payload_tdata,
    output wire                             tx_udp_payload_tvalid,
    input  wire                             tx_udp_payload_tready,
    output wire                             tx_udp_payload_tlast,
    output wire                             tx_udp_payload_tuser,

    output wire udp_echo_pkg::byte_t        led
);

    // Reply request, filter to sequencer
    wire                            echo_hdr_valid;
    wire                            echo_hdr_ready;
    wire udp_echo_pkg::ip_addr_t    echo_dest_ip;
    wire udp_echo_pkg::udp_port_t   echo_source_port;
    wire udp_echo_pkg::udp_port_t   echo_dest_port;
    wire udp_echo_pkg::udp_len_t    echo_length;

    // Kept payload into the FIFO
    wire udp_echo_pkg::byte_t       fifo_in_tdata;
    wire                            fifo_in_tvalid;
    wire                            fifo_in_tready;
    wire                            fifo_in_tlast;
    wire                            fifo_in_tuser;

    // Buffered payload out to the sequencer
    wire udp_echo_pkg::byte_t       fifo_out_tdata;
    wire                            fifo_out_tvalid;
    wire                            fifo_out_tready;
    wire                            fifo_out_tlast;
    wire                            fifo_out_tuser;

    // All port names match the nets above
    udp_rx_filter rx_filter_inst (.*);

    udp_payload_fifo payload_fifo_inst (.*);

    udp_echo_tx echo_tx_inst (.*);

endmodule

`default_nettype wire

//--- bench/udp_echo_frames.svh
/*
 * Echo test frames: received header fields, payload seed, tuser on the
 * last byte and whether the frame is expected to come back
 */
`ifndef UDP_ECHO_FRAMES_SVH
`define UDP_ECHO_FRAMES_SVH

localparam int NUM_FRAMES = 8;

typedef struct packed {
    logic [31:0] src_ip;
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] length;
    logic [7:0]  seed;
    logic        last_user;
    logic        echo;
} frame_t;

frame_t frame_table [NUM_FRAMES];

// UDP length counts the 8 header bytes, the rest is payload
// Columns: source IP, source port, dest port, length, seed, last tuser, echoed
task automatic load_frame_table();
    frame_table[0] = {32'hc0a8_0101, 16'd5000,  16'd1234, 16'd24, 8'h10, 1'b0, 1'b1};
    frame_table[1] = {32'hc0a8_0102, 16'd6000,  16'd80,   16'd20, 8'h20, 1'b0, 1'b0};
    frame_table[2] = {32'h0a00_0005, 16'd40000, 16'd1234, 16'd9,  8'ha5, 1'b1, 1'b1};
    frame_table[3] = {32'hc0a8_0103, 16'd1234,  16'd1235, 16'd16, 8'h30, 1'b1, 1'b0};
    // Seed near the top so the payload wraps past 8'hff
    frame_table[4] = {32'hac10_0001, 16'd1234,  16'd1234, 16'd40, 8'hf0, 1'b1, 1'b1};
    frame_table[5] = {32'hc0a8_0104, 16'd7,     16'd0,    16'd12, 8'h55, 1'b0, 1'b0};
    frame_table[6] = {32'h7f00_0001, 16'd65535, 16'd1234, 16'd72, 8'h80, 1'b0, 1'b1};
    frame_table[7] = {32'hc0a8_0105, 16'd3333,  16'd1234, 16'd17, 8'he8, 1'b1, 1'b1};
endtask

`endif

//--- bench/tb_udp_echo_core.sv
/*
 * Testbench for the UDP echo core: runs the frame table through the DUT
 * under random tx back-pressure and checks each echoed frame and the LEDs
 */
`timescale 1ns/1ps
`default_nettype none

module tb_udp_echo_core;

    localparam time         CLK_PERIOD  = 8;
    localparam time         DRIVE_DELAY = 1;
    localparam int          TIMEOUT     = 2000;
    localparam logic [31:0] SEED        = 32'h467b18ca;

    `include "udp_echo_frames.svh"

    logic                    clk_125mhz;
    logic                    rst_125mhz;
    logic                    rx_udp_hdr_valid;
    logic                    rx_udp_hdr_ready;
    udp_echo_pkg::ip_addr_t  rx_udp_ip_source_ip;
    udp_echo_pkg::udp_port_t rx_udp_source_port;
    udp_echo_pkg::udp_port_t rx_udp_dest_port;
    udp_echo_pkg::udp_len_t  rx_udp_length;
    udp_echo_pkg::byte_t     rx_udp_payload_tdata;
    logic                    rx_udp_payload_tvalid;
    logic                    rx_udp_payload_tready;
    logic                    rx_udp_payload_tlast;
    logic                    rx_udp_payload_tuser;
    logic                    tx_udp_hdr_valid;
    logic                    tx_udp_hdr_ready;
    udp_echo_pkg::ip_addr_t  tx_udp_ip_dest_ip;
    udp_echo_pkg::udp_port_t tx_udp_source_port;
    udp_echo_pkg::udp_port_t tx_udp_dest_port;
    udp_echo_pkg::udp_len_t  tx_udp_length;
    udp_echo_pkg::byte_t     tx_udp_payload_tdata;
    logic                    tx_udp_payload_tvalid;
    logic                    tx_udp_payload_tready;
    logic                    tx_udp_payload_tlast;
    logic                    tx_udp_payload_tuser;
    udp_echo_pkg::byte_t     led;

    // Monitor records: dest ip, source port, dest port, length / tuser, tlast, tdata
    logic [79:0]         hdr_seen [$];
    logic [9:0]          bytes_seen [$];
    udp_echo_pkg::byte_t led_seen [$];
    bit                  led_pending;

    udp_echo_core dut (.*);

    initial begin
        clk_125mhz = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_125mhz = ~clk_125mhz;
        end
    end

    // Stack side of the tx streams, randomly stalling
    initial begin
        logic [31:0] first_draw;
        tx_udp_hdr_ready      = 1'b0;
        tx_udp_payload_tready = 1'b0;
        first_draw = $urandom(SEED);
        forever begin
            @(posedge clk_125mhz);
            #(DRIVE_DELAY);
            tx_udp_hdr_ready      = ($urandom_range(3, 0) != 0);
            tx_udp_payload_tready = ($urandom_range(2, 0) != 0);
        end
    end

    // Sampled mid-cycle, where these values hold until the next rising edge
    always @(negedge clk_125mhz) begin
        if (!rst_125mhz) begin
            if (led_pending) begin
                led_seen.push_back(led);
                led_pending = 1'b0;
            end
            if (tx_udp_hdr_valid && tx_udp_hdr_ready) begin
                hdr_seen.push_back({tx_udp_ip_dest_ip, tx_udp_source_port,
                                    tx_udp_dest_port, tx_udp_length});
            end
            if (tx_udp_payload_tvalid && tx_udp_payload_tready) begin
                bytes_seen.push_back({tx_udp_payload_tuser, tx_udp_payload_tlast,
                                      tx_udp_payload_tdata});
                if (tx_udp_payload_tlast) begin
                    led_pending = 1'b1;
                end
            end
        end
    end

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            report_failure($sformatf("Fail %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    function automatic udp_echo_pkg::byte_t payload_byte(input frame_t fr, input int k);
        int sum;
        sum = fr.seed + k;
        return sum[7:0];
    endfunction

    // Holds the offered transfer until the DUT takes it on a rising edge
    task automatic wait_transfer(input bit is_header, input string what);
        int  cycles;
        bit  accepted;
        cycles = 0;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk_125mhz);
            accepted = is_header ? rx_udp_hdr_ready : rx_udp_payload_tready;
            @(posedge clk_125mhz);
            #(DRIVE_DELAY);
            cycles++;
            if (!accepted && cycles >= TIMEOUT) begin
                report_failure($sformatf("Timeout: the DUT never accepted %s", what));
            end
        end
    endtask

    // Waits until the given number of echoed frames have fully come back
    task automatic wait_echoes(input int count);
        int cycles;
        cycles = 0;
        while (led_seen.size() < count) begin
            @(negedge clk_125mhz);
            cycles++;
            if (led_seen.size() < count && cycles >= TIMEOUT) begin
                report_failure("Timeout: not every echoed frame came back from the DUT");
            end
        end
    endtask

    task automatic send_frame(input int idx);
        frame_t fr;
        int     n;
        fr = frame_table[idx];
        n = fr.length - 8;
        rx_udp_hdr_valid    = 1'b1;
        rx_udp_ip_source_ip = fr.src_ip;
        rx_udp_source_port  = fr.src_port;
        rx_udp_dest_port    = fr.dst_port;
        rx_udp_length       = fr.length;
        wait_transfer(1'b1, $sformatf("the header of frame %0d", idx));
        rx_udp_hdr_valid = 1'b0;
        for (int k = 0; k < n; k++) begin
            rx_udp_payload_tvalid = 1'b1;
            rx_udp_payload_tdata  = payload_byte(fr, k);
            rx_udp_payload_tlast  = (k == n - 1);
            rx_udp_payload_tuser  = (k == n - 1) ? fr.last_user : 1'b0;
            wait_transfer(1'b0, $sformatf("byte %0d of frame %0d", k, idx));
        end
        rx_udp_payload_tvalid = 1'b0;
        rx_udp_payload_tlast  = 1'b0;
        rx_udp_payload_tuser  = 1'b0;
    endtask

    // Expected reply: swapped ports, sender's IP as destination, same length
    task automatic check_echoes();
        frame_t              fr;
        int                  n;
        int                  e;
        int                  b;
        int                  total_hdrs;
        int                  total_bytes;
        udp_echo_pkg::byte_t last_led;
        e = 0;
        b = 0;
        total_hdrs = 0;
        total_bytes = 0;
        last_led = '0;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            if (frame_table[i].echo) begin
                total_hdrs++;
                total_bytes += frame_table[i].length - 8;
            end
        end
        check_value("tx header count", total_hdrs, hdr_seen.size());
        check_value("tx payload byte count", total_bytes, bytes_seen.size());
        for (int i = 0; i < NUM_FRAMES; i++) begin
            fr = frame_table[i];
            n = fr.length - 8;
            if (fr.echo) begin
                check_value($sformatf("frame %0d dest ip", i), fr.src_ip, hdr_seen[e][79:48]);
                check_value($sformatf("frame %0d source port", i), fr.dst_port,
                            hdr_seen[e][47:32]);
                check_value($sformatf("frame %0d dest port", i), fr.src_port,
                            hdr_seen[e][31:16]);
                check_value($sformatf("frame %0d length", i), fr.length, hdr_seen[e][15:0]);
                for (int k = 0; k < n; k++) begin
                    check_value($sformatf("frame %0d byte %0d data", i, k),
                                payload_byte(fr, k), bytes_seen[b][7:0]);
                    check_value($sformatf("frame %0d byte %0d tlast", i, k),
                                (k == n - 1), bytes_seen[b][8]);
                    if (k == n - 1) begin
                        check_value($sformatf("frame %0d tuser", i), fr.last_user,
                                    bytes_seen[b][9]);
                    end
                    b++;
                end
                last_led = payload_byte(fr, 0);
                check_value($sformatf("frame %0d led", i), last_led, led_seen[e]);
                e++;
            end
        end
        check_value("final led", last_led, led);
    endtask

    initial begin
        int                  echoes;
        udp_echo_pkg::byte_t expected_led;
        rst_125mhz            = 1'b1;
        rx_udp_hdr_valid      = 1'b0;
        rx_udp_ip_source_ip   = '0;
        rx_udp_source_port    = '0;
        rx_udp_dest_port      = '0;
        rx_udp_length         = '0;
        rx_udp_payload_tdata  = '0;
        rx_udp_payload_tvalid = 1'b0;
        rx_udp_payload_tlast  = 1'b0;
        rx_udp_payload_tuser  = 1'b0;
        load_frame_table();
        echoes = 0;
        expected_led = '0;
        repeat (3) @(posedge clk_125mhz);
        #(DRIVE_DELAY);
        rst_125mhz = 1'b0;
        @(negedge clk_125mhz);
        check_value("reset tx_udp_hdr_valid", 1'b0, tx_udp_hdr_valid);
        check_value("reset tx_udp_payload_tvalid", 1'b0, tx_udp_payload_tvalid);
        check_value("reset led", 8'h00, led);
        @(posedge clk_125mhz);
        #(DRIVE_DELAY);
        for (int i = 0; i < NUM_FRAMES; i++) begin
            send_frame(i);
            if (frame_table[i].echo) begin
                echoes++;
                expected_led = payload_byte(frame_table[i], 0);
            end else begin
                // Dropped frame must leave the LEDs on the last echoed first byte
                wait_echoes(echoes);
                check_value($sformatf("frame %0d dropped led", i), expected_led, led);
                @(posedge clk_125mhz);
                #(DRIVE_DELAY);
            end
        end
        wait_echoes(echoes);
        check_echoes();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+bench
design/udp_echo_pkg.sv
design/udp_rx_filter.sv
design/udp_payload_fifo.sv
design/udp_echo_tx.sv
design/udp_echo_core.sv
bench/tb_udp_echo_core.sv

//--- Bender.yml
package:
  name: udp_echo_core

sources:
  - design/udp_echo_pkg.sv
  - design/udp_rx_filter.sv
  - design/udp_payload_fifo.sv
  - design/udp_echo_tx.sv
  - design/udp_echo_core.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_udp_echo_core.sv
